// File: common/bus_bridge_settings.svh
`ifndef BUS_BRIDGE_SETTINGS_SVH
`define BUS_BRIDGE_SETTINGS_SVH

// bus widths
`define BB_ADDR_W 32
`define BB_DATA_W 32
`define BB_STRB_W 4

// arlen field as the AXI3 port carries it
`define BB_LEN_W 4

// transaction ids, one per source
`define BB_ID_W 2
`define BB_NUM_SRC 3

// request FIFO depth, reads and writes alike
`define BB_FIFO_DEPTH 4

`endif

// File: common/bus_bridge_pkg.sv
`default_nettype none
`include "bus_bridge_settings.svh"

package bus_bridge_pkg;

	////////////////////////////////////////
	// transaction ids
	////////////////////////////////////////

	// the id of a transaction names the source it returns to
	typedef enum logic [`BB_ID_W-1:0] {
		SRC_FETCH = 2'd0,
		SRC_LANE0 = 2'd1,
		SRC_LANE1 = 2'd2
	} source_e;

	////////////////////////////////////////
	// request payloads
	////////////////////////////////////////

	// len is 1 for an instruction pair, 0 for a single load
	typedef struct packed {
		source_e id;
		logic [`BB_ADDR_W-1:0] addr;
		logic [`BB_LEN_W-1:0] len;
	} rd_req_t;

	typedef struct packed {
		source_e id;
		logic [`BB_ADDR_W-1:0] addr;
		logic [`BB_DATA_W-1:0] data;
		logic [`BB_STRB_W-1:0] strb;
	} wr_req_t;

endpackage

`default_nettype wire

// File: common/bus_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// valid/ready request link between arbiter, FIFO and AXI master
interface bus_req_if #(
	parameter type payload_t = logic
) ();

	logic valid;
	logic ready;
	payload_t payload;

	// side that offers requests, holds valid and payload until ready
	modport producer (
		output valid,
		output payload,
		input ready
	);

	// side that takes requests
	modport consumer (
		input valid,
		input payload,
		output ready
	);

endinterface

`default_nettype wire

// File: design/bus_request_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_bridge_settings.svh"

module bus_request_arbiter (
	input wire clk,
	input wire reset,
	input wire fetch_req,
	input wire [`BB_ADDR_W-1:0] fetch_addr,
	input wire lane0_load,
	input wire lane0_store,
	input wire [`BB_ADDR_W-1:0] lane0_addr,
	input wire [`BB_DATA_W-1:0] lane0_wdata,
	input wire [`BB_STRB_W-1:0] lane0_wstrb,
	input wire lane1_load,
	input wire lane1_store,
	input wire [`BB_ADDR_W-1:0] lane1_addr,
	input wire [`BB_DATA_W-1:0] lane1_wdata,
	input wire [`BB_STRB_W-1:0] lane1_wstrb,
	input wire fetch_done,
	input wire lane0_done,
	input wire lane1_done,
	bus_req_if.producer rd_arb,
	bus_req_if.producer wr_arb
);

	logic [`BB_NUM_SRC-1:0] pend;
	logic [`BB_NUM_SRC-1:0] done_vec;
	logic [`BB_NUM_SRC-1:0] free;
	logic rd_any;
	logic wr_any;
	logic rd_fire;
	logic wr_fire;
	bus_bridge_pkg::rd_req_t rd_next;
	bus_bridge_pkg::wr_req_t wr_next;

	assign done_vec[bus_bridge_pkg::SRC_FETCH] = fetch_done;
	assign done_vec[bus_bridge_pkg::SRC_LANE0] = lane0_done;
	assign done_vec[bus_bridge_pkg::SRC_LANE1] = lane1_done;

	// a level seen together with its done pulse is the old request
	assign free = ~pend & ~done_vec;

	assign rd_any = (fetch_req & free[bus_bridge_pkg::SRC_FETCH])
		| (lane0_load & free[bus_bridge_pkg::SRC_LANE0])
		| (lane1_load & free[bus_bridge_pkg::SRC_LANE1]);
	assign wr_any = (lane0_store & free[bus_bridge_pkg::SRC_LANE0])
		| (lane1_store & free[bus_bridge_pkg::SRC_LANE1]);

	assign rd_fire = rd_arb.valid & rd_arb.ready;
	assign wr_fire = wr_arb.valid & wr_arb.ready;

	////////////////////////////////////////
	// priority pick
	////////////////////////////////////////

	// reads: fetch, lane 0, lane 1
	always_comb
	begin
		rd_next.id = bus_bridge_pkg::SRC_LANE1;
		rd_next.addr = lane1_addr;
		rd_next.len = '0;
		if (fetch_req && free[bus_bridge_pkg::SRC_FETCH])
		begin
			rd_next.id = bus_bridge_pkg::SRC_FETCH;
			rd_next.addr = fetch_addr;
			// two-beat burst for the pair
			rd_next.len = {{(`BB_LEN_W-1){1'b0}}, 1'b1};
		end
		else if (lane0_load && free[bus_bridge_pkg::SRC_LANE0])
		begin
			rd_next.id = bus_bridge_pkg::SRC_LANE0;
			rd_next.addr = lane0_addr;
		end
	end

	// writes: lane 0, lane 1
	always_comb
	begin
		wr_next.id = bus_bridge_pkg::SRC_LANE1;
		wr_next.addr = lane1_addr;
		wr_next.data = lane1_wdata;
		wr_next.strb = lane1_wstrb;
		if (lane0_store && free[bus_bridge_pkg::SRC_LANE0])
		begin
			wr_next.id = bus_bridge_pkg::SRC_LANE0;
			wr_next.addr = lane0_addr;
			wr_next.data = lane0_wdata;
			wr_next.strb = lane0_wstrb;
		end
	end

	////////////////////////////////////////
	// offer and hold until transfer
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_arb.valid <= 1'b0;
			wr_arb.valid <= 1'b0;
		end
		else
		begin
			if (rd_fire)
				rd_arb.valid <= 1'b0;
			else if (!rd_arb.valid && rd_any)
				rd_arb.valid <= 1'b1;
			if (wr_fire)
				wr_arb.valid <= 1'b0;
			else if (!wr_arb.valid && wr_any)
				wr_arb.valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rd_arb.valid && rd_any)
			rd_arb.payload <= rd_next;
		if (!wr_arb.valid && wr_any)
			wr_arb.payload <= wr_next;
	end

	// one transaction in flight per source
	always_ff @(posedge clk)
	begin
		if (reset)
			pend <= '0;
		else
		begin
			for (int i = 0; i < `BB_NUM_SRC; i++)
			begin
				if (done_vec[i])
					pend[i] <= 1'b0;
				else if ((rd_fire && rd_arb.payload.id == i)
					|| (wr_fire && wr_arb.payload.id == i))
					pend[i] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/request_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_bridge_settings.svh"

module request_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = `BB_FIFO_DEPTH
) (
	input wire clk,
	input wire reset,
	bus_req_if.consumer in,
	bus_req_if.producer out
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// full stalls the producer
	assign in.ready = (count != CNT_W'(DEPTH));
	assign out.valid = (count != '0);
	assign out.payload = mem[rd_ptr];

	assign push = in.valid & in.ready;
	assign pop = out.valid & out.ready;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in.payload;
	end

	////////////////////////////////////////
	// pointers and fill level
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: axi_master/axi_channel_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_bridge_settings.svh"

module axi_channel_master (
	input wire clk,
	input wire reset,
	bus_req_if.consumer rd_bus,
	bus_req_if.consumer wr_bus,
	// read address
	output logic [`BB_ID_W-1:0] arid,
	output logic [`BB_ADDR_W-1:0] araddr,
	output logic [`BB_LEN_W-1:0] arlen,
	output logic arvalid,
	input wire arready,
	// read data
	input wire [`BB_ID_W-1:0] rid,
	input wire [`BB_DATA_W-1:0] rdata,
	input wire rlast,
	input wire rvalid,
	// write address and data
	output logic [`BB_ID_W-1:0] awid,
	output logic [`BB_ADDR_W-1:0] awaddr,
	output logic awvalid,
	input wire awready,
	output logic [`BB_DATA_W-1:0] wdata,
	output logic [`BB_STRB_W-1:0] wstrb,
	output logic wlast,
	output logic wvalid,
	input wire wready,
	// write response
	input wire [`BB_ID_W-1:0] bid,
	input wire bvalid,
	// beats to the router
	output logic r_valid,
	output logic [`BB_ID_W-1:0] r_id,
	output logic [`BB_DATA_W-1:0] r_data,
	output logic r_last,
	output logic b_valid,
	output logic [`BB_ID_W-1:0] b_id
);

	logic wr_busy;
	logic aw_sent;
	logic w_sent;
	logic aw_done;
	logic w_done;

	////////////////////////////////////////
	// AR channel
	////////////////////////////////////////

	// next head only once the address is gone
	assign rd_bus.ready = ~arvalid;

	always_ff @(posedge clk)
	begin
		if (reset)
			arvalid <= 1'b0;
		else if (arvalid && arready)
			arvalid <= 1'b0;
		else if (!arvalid && rd_bus.valid)
			arvalid <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!arvalid && rd_bus.valid)
		begin
			arid <= rd_bus.payload.id;
			araddr <= rd_bus.payload.addr;
			arlen <= rd_bus.payload.len;
		end
	end

	////////////////////////////////////////
	// AW and W channels
	////////////////////////////////////////

	assign wr_bus.ready = ~wr_busy;

	// both offered together, each drops on its own handshake
	assign awvalid = wr_busy & ~aw_sent;
	assign wvalid = wr_busy & ~w_sent;
	// single-beat writes
	assign wlast = 1'b1;

	assign aw_done = aw_sent | (awvalid & awready);
	assign w_done = w_sent | (wvalid & wready);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_busy <= 1'b0;
			aw_sent <= 1'b0;
			w_sent <= 1'b0;
		end
		else if (!wr_busy)
			wr_busy <= wr_bus.valid;
		else if (aw_done && w_done)
		begin
			wr_busy <= 1'b0;
			aw_sent <= 1'b0;
			w_sent <= 1'b0;
		end
		else
		begin
			aw_sent <= aw_done;
			w_sent <= w_done;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!wr_busy && wr_bus.valid)
		begin
			awid <= wr_bus.payload.id;
			awaddr <= wr_bus.payload.addr;
			wdata <= wr_bus.payload.data;
			wstrb <= wr_bus.payload.strb;
		end
	end

	// R and B are always accepted, passed on as they arrive
	assign r_valid = rvalid;
	assign r_id = rid;
	assign r_data = rdata;
	assign r_last = rlast;
	assign b_valid = bvalid;
	assign b_id = bid;

endmodule

`default_nettype wire

// File: design/response_router.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_bridge_settings.svh"

module response_router (
	input wire clk,
	input wire reset,
	// R beats
	input wire r_valid,
	input wire [`BB_ID_W-1:0] r_id,
	input wire [`BB_DATA_W-1:0] r_data,
	input wire r_last,
	// B completions
	input wire b_valid,
	input wire [`BB_ID_W-1:0] b_id,
	// instruction pair
	output logic fetch_done,
	output logic [`BB_DATA_W-1:0] fetch_inst_0,
	output logic [`BB_DATA_W-1:0] fetch_inst_1,
	// lanes
	output logic lane0_done,
	output logic [`BB_DATA_W-1:0] lane0_rdata,
	output logic lane1_done,
	output logic [`BB_DATA_W-1:0] lane1_rdata
);

	logic fetch_sel;
	logic r_fetch;
	logic r_lane0;
	logic r_lane1;
	logic b_lane0;
	logic b_lane1;

	assign r_fetch = r_valid && (r_id == bus_bridge_pkg::SRC_FETCH);
	assign r_lane0 = r_valid && (r_id == bus_bridge_pkg::SRC_LANE0);
	assign r_lane1 = r_valid && (r_id == bus_bridge_pkg::SRC_LANE1);
	assign b_lane0 = b_valid && (b_id == bus_bridge_pkg::SRC_LANE0);
	assign b_lane1 = b_valid && (b_id == bus_bridge_pkg::SRC_LANE1);

	////////////////////////////////////////
	// instruction pair assembly
	////////////////////////////////////////

	// word select, 0 waits for the first beat
	always_ff @(posedge clk)
	begin
		if (reset)
			fetch_sel <= 1'b0;
		else if (r_fetch)
			fetch_sel <= ~r_last;
	end

	always_ff @(posedge clk)
	begin
		if (r_fetch && !fetch_sel)
			fetch_inst_0 <= r_data;
		if (r_fetch && fetch_sel)
			fetch_inst_1 <= r_data;
	end

	////////////////////////////////////////
	// load data and done pulses
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (r_lane0)
			lane0_rdata <= r_data;
		if (r_lane1)
			lane1_rdata <= r_data;
	end

	// a lane has one load or one store out, never both
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fetch_done <= 1'b0;
			lane0_done <= 1'b0;
			lane1_done <= 1'b0;
		end
		else
		begin
			fetch_done <= r_fetch & r_last;
			lane0_done <= r_lane0 | b_lane0;
			lane1_done <= r_lane1 | b_lane1;
		end
	end

endmodule

`default_nettype wire

// File: design/bus_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_bridge_settings.svh"

module bus_bridge_top (
	input wire clk,
	input wire reset,
	// fetch source
	input wire fetch_req,
	input wire [`BB_ADDR_W-1:0] fetch_addr,
	output logic fetch_done,
	output logic [`BB_DATA_W-1:0] fetch_inst_0,
	output logic [`BB_DATA_W-1:0] fetch_inst_1,
	// lane 0
	input wire lane0_load,
	input wire lane0_store,
	input wire [`BB_ADDR_W-1:0] lane0_addr,
	input wire [`BB_DATA_W-1:0] lane0_wdata,
	input wire [`BB_STRB_W-1:0] lane0_wstrb,
	output logic lane0_done,
	output logic [`BB_DATA_W-1:0] lane0_rdata,
	// lane 1
	input wire lane1_load,
	input wire lane1_store,
	input wire [`BB_ADDR_W-1:0] lane1_addr,
	input wire [`BB_DATA_W-1:0] lane1_wdata,
	input wire [`BB_STRB_W-1:0] lane1_wstrb,
	output logic lane1_done,
	output logic [`BB_DATA_W-1:0] lane1_rdata,
	// AXI master port
	output logic [`BB_ID_W-1:0] arid,
	output logic [`BB_ADDR_W-1:0] araddr,
	output logic [`BB_LEN_W-1:0] arlen,
	output logic arvalid,
	input wire arready,
	input wire [`BB_ID_W-1:0] rid,
	input wire [`BB_DATA_W-1:0] rdata,
	input wire rlast,
	input wire rvalid,
	output logic [`BB_ID_W-1:0] awid,
	output logic [`BB_ADDR_W-1:0] awaddr,
	output logic awvalid,
	input wire awready,
	output logic [`BB_DATA_W-1:0] wdata,
	output logic [`BB_STRB_W-1:0] wstrb,
	output logic wlast,
	output logic wvalid,
	input wire wready,
	input wire [`BB_ID_W-1:0] bid,
	input wire bvalid
);

	logic r_valid;
	logic [`BB_ID_W-1:0] r_id;
	logic [`BB_DATA_W-1:0] r_data;
	logic r_last;
	logic b_valid;
	logic [`BB_ID_W-1:0] b_id;

	// arbiter to FIFO, FIFO to AXI master
	bus_req_if #(.payload_t(bus_bridge_pkg::rd_req_t)) rd_arb ();
	bus_req_if #(.payload_t(bus_bridge_pkg::wr_req_t)) wr_arb ();
	bus_req_if #(.payload_t(bus_bridge_pkg::rd_req_t)) rd_bus ();
	bus_req_if #(.payload_t(bus_bridge_pkg::wr_req_t)) wr_bus ();

	bus_request_arbiter u_arbiter (.*);

	request_fifo #(.payload_t(bus_bridge_pkg::rd_req_t)) rd_fifo (
		.clk(clk), .reset(reset), .in(rd_arb), .out(rd_bus)
	);

	request_fifo #(.payload_t(bus_bridge_pkg::wr_req_t)) wr_fifo (
		.clk(clk), .reset(reset), .in(wr_arb), .out(wr_bus)
	);

	axi_channel_master u_master (.*);

	response_router u_router (.*);

endmodule

`default_nettype wire

// File: tb/axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_bridge_settings.svh"

module axi_slave_model #(
	parameter logic [31:0] BASE = 32'h0000_2000,
	parameter int MEM_WORDS = 32,
	parameter integer SEED = 1
) (
	input wire clk,
	input wire reset,
	input wire [`BB_ID_W-1:0] arid,
	input wire [`BB_ADDR_W-1:0] araddr,
	input wire [`BB_LEN_W-1:0] arlen,
	input wire arvalid,
	output logic arready,
	output logic [`BB_ID_W-1:0] rid,
	output logic [`BB_DATA_W-1:0] rdata,
	output logic rlast,
	output logic rvalid,
	input wire [`BB_ID_W-1:0] awid,
	input wire [`BB_ADDR_W-1:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire [`BB_DATA_W-1:0] wdata,
	input wire [`BB_STRB_W-1:0] wstrb,
	input wire wvalid,
	output logic wready,
	output logic [`BB_ID_W-1:0] bid,
	output logic bvalid
);

	logic [`BB_DATA_W-1:0] mem [MEM_WORDS];
	logic [`BB_ID_W-1:0] ar_id_q [$];
	logic [`BB_ADDR_W-1:0] ar_addr_q [$];
	logic [`BB_LEN_W-1:0] ar_len_q [$];
	logic [`BB_ID_W-1:0] aw_id_q [$];
	logic [`BB_ADDR_W-1:0] aw_addr_q [$];
	logic [`BB_DATA_W-1:0] w_data_q [$];
	logic [`BB_STRB_W-1:0] w_strb_q [$];
	logic active;
	integer seed;
	int beat;
	int idx;

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h0001_0003) ^ 32'h6b4d_92e1 ^ {addr[7:0], addr[31:8]};
	endfunction

	function automatic int word_idx(input logic [31:0] addr);
		return ((addr - BASE) >> 2) % MEM_WORDS;
	endfunction

	initial
	begin
		seed = SEED;
		active = 1'b0;
		beat = 0;
		arready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rid = '0;
		rdata = '0;
		bvalid = 1'b0;
		bid = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = fill_word(BASE + 4 * i);
	end

	////////////////////////////////////////
	// capture handshakes at the clock edge
	////////////////////////////////////////

	always @(posedge clk)
	begin
		active <= !reset;
		if (!reset && arvalid && arready)
		begin
			ar_id_q.push_back(arid);
			ar_addr_q.push_back(araddr);
			ar_len_q.push_back(arlen);
		end
		if (!reset && awvalid && awready)
		begin
			aw_id_q.push_back(awid);
			aw_addr_q.push_back(awaddr);
		end
		if (!reset && wvalid && wready)
		begin
			w_data_q.push_back(wdata);
			w_strb_q.push_back(wstrb);
		end
	end

	////////////////////////////////////////
	// responses on the falling edge
	////////////////////////////////////////

	always @(negedge clk)
	begin
		if (active)
		begin
			// ready about three cycles in four
			arready <= ($random(seed) & 3) != 0;
			awready <= ($random(seed) & 3) != 0;
			wready <= ($random(seed) & 3) != 0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			// oldest burst, one word per beat, random gaps
			if (ar_id_q.size() != 0 && ($random(seed) & 1))
			begin
				rvalid <= 1'b1;
				rid <= ar_id_q[0];
				rdata <= mem[word_idx(ar_addr_q[0] + 4 * beat)];
				rlast <= (beat == ar_len_q[0]);
				if (beat == ar_len_q[0])
				begin
					void'(ar_id_q.pop_front());
					void'(ar_addr_q.pop_front());
					void'(ar_len_q.pop_front());
					beat = 0;
				end
				else
					beat = beat + 1;
			end
			bvalid <= 1'b0;
			// write lands in memory when its B goes out
			if (aw_id_q.size() != 0 && w_data_q.size() != 0 && ($random(seed) & 1))
			begin
				idx = word_idx(aw_addr_q[0]);
				for (int b = 0; b < `BB_STRB_W; b++)
					if (w_strb_q[0][b])
						mem[idx][8*b +: 8] = w_data_q[0][8*b +: 8];
				bvalid <= 1'b1;
				bid <= aw_id_q.pop_front();
				void'(aw_addr_q.pop_front());
				void'(w_data_q.pop_front());
				void'(w_strb_q.pop_front());
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/bus_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_bridge_settings.svh"

module bus_bridge_tb;

	localparam logic [31:0] BASE = 32'h0000_2000;
	localparam int MEM_WORDS = 32;
	localparam int N_RAND = 60;
	// three directed reads, two directed stores, store and load readback
	localparam int N_TXN = 3 * N_RAND + 7;

	logic clk;
	logic reset;
	logic fetch_req, fetch_done;
	logic [`BB_ADDR_W-1:0] fetch_addr;
	logic [`BB_DATA_W-1:0] fetch_inst_0, fetch_inst_1;
	logic lane0_load, lane0_store, lane0_done;
	logic lane1_load, lane1_store, lane1_done;
	logic [`BB_ADDR_W-1:0] lane0_addr, lane1_addr;
	logic [`BB_DATA_W-1:0] lane0_wdata, lane0_rdata, lane1_wdata, lane1_rdata;
	logic [`BB_STRB_W-1:0] lane0_wstrb, lane1_wstrb;
	logic [`BB_ID_W-1:0] arid, rid, awid, bid;
	logic [`BB_ADDR_W-1:0] araddr, awaddr;
	logic [`BB_LEN_W-1:0] arlen;
	logic arvalid, arready, rvalid, rlast, awvalid, awready;
	logic [`BB_DATA_W-1:0] rdata, wdata;
	logic [`BB_STRB_W-1:0] wstrb;
	logic wvalid, wready, wlast, bvalid;

	logic [`BB_DATA_W-1:0] model [MEM_WORDS];
	logic [`BB_ID_W-1:0] ar_order [$];
	logic [`BB_ID_W-1:0] aw_order [$];
	logic ar_hold, aw_hold, w_hold;
	logic [63:0] ar_prev, aw_prev, w_prev;
	int issued [3] = '{0, 0, 0};
	int done_cnt [3] = '{0, 0, 0};
	int checks = 0;
	int errors = 0;
	integer seed = 32'h51e8_2df7;

	bus_bridge_top UUT (.*);

	axi_slave_model #(.BASE(BASE), .MEM_WORDS(MEM_WORDS), .SEED(32'h51e8_2df7)) u_slave (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic compare(input string what, input logic [63:0] got,
		input logic [63:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
		end
	endtask

	// initial memory contents, a function of the byte address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h0001_0003) ^ 32'h6b4d_92e1 ^ {addr[7:0], addr[31:8]};
	endfunction

	////////////////////////////////////////
	// source drivers, entered on a falling edge
	////////////////////////////////////////

	task automatic do_fetch(input int word);
		logic [31:0] exp0;
		logic [31:0] exp1;
		exp0 = model[word];
		exp1 = model[word + 1];
		fetch_addr = BASE + 4 * word;
		fetch_req = 1'b1;
		issued[0]++;
		do
			@(negedge clk);
		while (!fetch_done);
		compare("fetch_inst_0", fetch_inst_0, exp0);
		compare("fetch_inst_1", fetch_inst_1, exp1);
		fetch_req = 1'b0;
	endtask

	task automatic lane_access(input int lane, input bit store, input int word,
		input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] expected;
		expected = model[word];
		if (lane == 0)
		begin
			lane0_addr = BASE + 4 * word;
			lane0_wdata = data;
			lane0_wstrb = strb;
			lane0_load = !store;
			lane0_store = store;
		end
		else
		begin
			lane1_addr = BASE + 4 * word;
			lane1_wdata = data;
			lane1_wstrb = strb;
			lane1_load = !store;
			lane1_store = store;
		end
		issued[lane + 1]++;
		do
			@(negedge clk);
		while (!(lane == 0 ? lane0_done : lane1_done));
		if (store)
		begin
			// byte merge under the strobe
			for (int b = 0; b < 4; b++)
				if (strb[b])
					model[word][8*b +: 8] = data[8*b +: 8];
		end
		else if (lane == 0)
			compare("lane0 load data", lane0_rdata, expected);
		else
			compare("lane1 load data", lane1_rdata, expected);
		if (lane == 0)
		begin
			lane0_load = 1'b0;
			lane0_store = 1'b0;
		end
		else
		begin
			lane1_load = 1'b0;
			lane1_store = 1'b0;
		end
	endtask

	// fetch reads words 16 to 31, never stored
	task automatic run_fetch();
		for (int i = 0; i < N_RAND; i++)
		begin
			repeat (1 + ($random(seed) & 7)) @(negedge clk);
			do_fetch(16 + ($unsigned($random(seed)) % 15));
		end
	endtask

	// each lane owns eight words, so its loads follow its own stores
	task automatic run_lane(input int lane);
		int word;
		bit store;
		for (int i = 0; i < N_RAND; i++)
		begin
			repeat (1 + ($random(seed) & 7)) @(negedge clk);
			word = 8 * lane + ($random(seed) & 7);
			store = $random(seed) & 1;
			lane_access(lane, store, word, $random(seed), $random(seed) & 15);
		end
	endtask

	////////////////////////////////////////
	// bus monitor
	////////////////////////////////////////

	always @(posedge clk)
	begin
		if (reset)
		begin
			ar_hold <= 1'b0;
			aw_hold <= 1'b0;
			w_hold <= 1'b0;
		end
		else
		begin
			if (ar_hold)
			begin
				compare("arvalid held until arready", arvalid, 1'b1);
				compare("AR payload stable", {arid, araddr, arlen}, ar_prev);
			end
			if (aw_hold)
			begin
				compare("awvalid held until awready", awvalid, 1'b1);
				compare("AW payload stable", {awid, awaddr}, aw_prev);
			end
			if (w_hold)
			begin
				compare("wvalid held until wready", wvalid, 1'b1);
				compare("W payload stable", {wdata, wstrb}, w_prev);
			end
			if (wvalid)
				compare("wlast on single-beat write", wlast, 1'b1);
			ar_hold <= arvalid && !arready;
			aw_hold <= awvalid && !awready;
			w_hold <= wvalid && !wready;
			ar_prev <= {arid, araddr, arlen};
			aw_prev <= {awid, awaddr};
			w_prev <= {wdata, wstrb};
			if (arvalid && arready)
				ar_order.push_back(arid);
			if (awvalid && awready)
				aw_order.push_back(awid);
			if (fetch_done)
				done_cnt[0] <= done_cnt[0] + 1;
			if (lane0_done)
				done_cnt[1] <= done_cnt[1] + 1;
			if (lane1_done)
				done_cnt[2] <= done_cnt[2] + 1;
		end
	end

	initial
	begin
		#(N_TXN * 40 * 100);
		$display("timeout: requests still open after %0d ns, %0d errors so far",
			N_TXN * 40 * 100, errors);
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		fetch_req = 1'b0;
		fetch_addr = '0;
		lane0_load = 1'b0;
		lane0_store = 1'b0;
		lane0_addr = '0;
		lane0_wdata = '0;
		lane0_wstrb = '0;
		lane1_load = 1'b0;
		lane1_store = 1'b0;
		lane1_addr = '0;
		lane1_wdata = '0;
		lane1_wstrb = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			model[i] = fill_word(BASE + 4 * i);
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// quiet bus until the first request
		repeat (3)
		begin
			@(negedge clk);
			compare("idle after reset",
				{arvalid, awvalid, wvalid, fetch_done, lane0_done, lane1_done}, '0);
		end

		// all three reads raised together
		ar_order.delete();
		fork
			do_fetch(20);
			lane_access(0, 1'b0, 2, '0, '0);
			lane_access(1, 1'b0, 9, '0, '0);
		join
		compare("AR handshake count", ar_order.size(), 3);
		for (int i = 0; i < 3; i++)
			compare("AR id order", ar_order[i], i);

		// both lanes store together
		@(negedge clk);
		aw_order.delete();
		fork
			lane_access(0, 1'b1, 4, $random(seed), 4'hf);
			lane_access(1, 1'b1, 12, $random(seed), 4'hf);
		join
		compare("AW handshake count", aw_order.size(), 2);
		compare("first AW id", aw_order[0], 1);
		compare("second AW id", aw_order[1], 2);

		// partial store, then read back the merged word
		@(negedge clk);
		lane_access(0, 1'b1, 3, $random(seed), 4'b0101);
		@(negedge clk);
		lane_access(0, 1'b0, 3, '0, '0);

		@(negedge clk);
		fork
			run_fetch();
			run_lane(0);
			run_lane(1);
		join

		repeat (4) @(negedge clk);
		compare("fetch_done count", done_cnt[0], issued[0]);
		compare("lane0_done count", done_cnt[1], issued[1]);
		compare("lane1_done count", done_cnt[2], issued[2]);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/bus_bridge_pkg.sv
common/bus_req_if.sv
design/bus_request_arbiter.sv
design/request_fifo.sv
axi_master/axi_channel_master.sv
design/response_router.sv
design/bus_bridge_top.sv
tb/axi_slave_model.sv
tb/bus_bridge_tb.sv

// File: Bender.yml
package:
  name: bus_bridge

export_include_dirs:
  - common

sources:
  - files:
      - common/bus_bridge_pkg.sv
      - common/bus_req_if.sv
      - design/bus_request_arbiter.sv
      - design/request_fifo.sv
      - axi_master/axi_channel_master.sv
      - design/response_router.sv
      - design/bus_bridge_top.sv
  - target: test
    files:
      - tb/axi_slave_model.sv
      - tb/bus_bridge_tb.sv
